/* hw/pulse_meter_pkg.sv */
package pulse_meter_pkg;

    ////////////////////////////////////////////////////////////
    // Counter geometry
    ////////////////////////////////////////////////////////////

    // Eight decades, so up to 99,999,999 counts per window
    localparam int num_digits = 8;

    // One second at 100 MHz
    localparam int default_gate_cycles = 100_000_000;

    typedef logic [3:0] bcd_digit_t;

    // Highest legal value of one decade
    localparam bcd_digit_t bcd_max = 4'd9;

    ////////////////////////////////////////////////////////////
    // Count and result words
    ////////////////////////////////////////////////////////////

    // Digit 0 is the least significant decade
    typedef struct packed {
        logic                              overflow;
        bcd_digit_t [num_digits-1:0]       digits;
    } bcd_count_t;

    // What the host sees for one window
    typedef struct packed {
        logic       missed;
        bcd_count_t count;
    } meas_result_t;

endpackage

/* hw/gate_timer.sv */
module gate_timer #(
    parameter int gate_cycles = pulse_meter_pkg::default_gate_cycles
) (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    output logic gate_open,
    output logic gate_done
);

    // Position inside the open window from 0 to gate_cycles-1
    localparam int cnt_w = (gate_cycles > 1) ? $clog2(gate_cycles) : 1;

    logic [cnt_w-1:0] cnt_q;
    logic             last_cycle;

    assign last_cycle = (cnt_q == cnt_w'(gate_cycles - 1));

    ////////////////////////////////////////////////////////////
    // Window sequencing
    ////////////////////////////////////////////////////////////

    // Open for gate_cycles, then one idle cycle, then open again
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gate_open <= 1'b0;
            cnt_q     <= '0;
        end else if (!en) begin
            // Back to idle so the next enable starts a full window
            gate_open <= 1'b0;
            cnt_q     <= '0;
        end else if (!gate_open) begin
            gate_open <= 1'b1;
            cnt_q     <= '0;
        end else if (last_cycle) begin
            gate_open <= 1'b0;
            cnt_q     <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // End-of-window strobe in the last open cycle
    assign gate_done = gate_open & en & last_cycle;

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    // An enabled window closes only right after its end strobe
    a_close_after_done: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($fell(gate_open) && $past(en)) |-> $past(gate_done)
    );

endmodule

/* hw/decade_counter.sv */
module decade_counter (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        en,
    input  logic                        pulse,
    input  logic                        gate_open,
    output pulse_meter_pkg::bcd_count_t count
);

    ////////////////////////////////////////////////////////////
    // Input synchronizer and edge detect
    ////////////////////////////////////////////////////////////

    logic sync1_q;
    logic sync2_q;
    logic edge_q;
    logic pulse_rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            edge_q  <= 1'b0;
        end else if (!en) begin
            sync1_q <= 1'b0;
            sync2_q <= 1'b0;
            edge_q  <= 1'b0;
        end else begin
            sync1_q <= pulse;
            sync2_q <= sync1_q;
            edge_q  <= sync2_q;
        end
    end

    assign pulse_rise = sync2_q & ~edge_q;

    // Window start detect, used to restart the count
    logic gate_q;
    logic gate_rise;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gate_q <= 1'b0;
        end else begin
            gate_q <= gate_open & en;
        end
    end

    assign gate_rise = gate_open & ~gate_q;

    ////////////////////////////////////////////////////////////
    // Cascaded decades
    ////////////////////////////////////////////////////////////

    // carry[i] increments decade i; carry[num_digits] is the overflow
    logic [pulse_meter_pkg::num_digits:0]                               carry;
    pulse_meter_pkg::bcd_digit_t [pulse_meter_pkg::num_digits-1:0]     digits;
    logic                                                               overflow_q;

    assign carry[0] = pulse_rise & gate_open;

    for (genvar i = 0; i < pulse_meter_pkg::num_digits; i++) begin : g_decade
        pulse_meter_pkg::bcd_digit_t digit_q;
        pulse_meter_pkg::bcd_digit_t base;
        logic                        at_max;

        // First window cycle counts from zero
        assign base   = gate_rise ? '0 : digit_q;
        assign at_max = (base == pulse_meter_pkg::bcd_max);

        // Carry ripples through in the same cycle
        assign carry[i+1] = carry[i] & at_max;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                digit_q <= '0;
            end else if (!en) begin
                digit_q <= '0;
            end else if (carry[i]) begin
                digit_q <= at_max ? '0 : base + 1'b1;
            end else begin
                digit_q <= base;
            end
        end

        assign digits[i] = digit_q;

        a_digit_bcd: assert property (
            @(posedge clk) disable iff (!rst_n)
            digit_q <= pulse_meter_pkg::bcd_max
        );
    end

    // Sticky until the next window starts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            overflow_q <= 1'b0;
        end else if (!en) begin
            overflow_q <= 1'b0;
        end else if (gate_rise) begin
            overflow_q <= carry[pulse_meter_pkg::num_digits];
        end else if (carry[pulse_meter_pkg::num_digits]) begin
            overflow_q <= 1'b1;
        end
    end

    assign count.overflow = overflow_q;
    assign count.digits   = digits;

endmodule

/* hw/result_readout.sv */
module result_readout (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          gate_done,
    input  pulse_meter_pkg::bcd_count_t   count,
    output pulse_meter_pkg::meas_result_t result,
    output logic                          req,
    input  logic                          ack
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_wait_ack_low
    } state_t;

    state_t state_q;
    logic   lost_q;
    logic   can_load;

    // Free once the previous ack has been seen low
    assign can_load = (state_q == st_idle) ||
                      ((state_q == st_wait_ack_low) && !ack);

    ////////////////////////////////////////////////////////////
    // Handshake FSM and result register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            lost_q  <= 1'b0;
            result  <= '0;
        end else if (!en) begin
            state_q <= st_idle;
            lost_q  <= 1'b0;
            result  <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (gate_done) begin
                        state_q <= st_req;
                    end
                end
                st_req: begin
                    if (ack) begin
                        state_q <= st_wait_ack_low;
                    end
                end
                st_wait_ack_low: begin
                    // ack low and a fresh window ready, go straight back to req
                    if (!ack) begin
                        state_q <= gate_done ? st_req : st_idle;
                    end
                end
                default: state_q <= st_idle;
            endcase

            if (gate_done) begin
                if (can_load) begin
                    result.count  <= count;
                    result.missed <= lost_q;
                    lost_q        <= 1'b0;
                end else begin
                    // Host still busy, this window is dropped
                    lost_q <= 1'b1;
                end
            end
        end
    end

    assign req = (state_q == st_req);

    ////////////////////////////////////////////////////////////
    // Handshake checks
    ////////////////////////////////////////////////////////////

    a_req_holds: assert property (
        @(posedge clk) disable iff (!rst_n || !en)
        $fell(req) |-> $past(ack)
    );

    a_result_stable: assert property (
        @(posedge clk) disable iff (!rst_n || !en)
        (req && !ack) |=> $stable(result)
    );

endmodule

/* hw/pulse_meter_top.sv */
module pulse_meter_top #(
    parameter int gate_cycles = pulse_meter_pkg::default_gate_cycles
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          pulse,
    input  logic                          ack,
    output pulse_meter_pkg::meas_result_t result,
    output logic                          req,
    output logic                          gate
);

    ////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////

    logic                        gate_done;
    pulse_meter_pkg::bcd_count_t count;

    ////////////////////////////////////////////////////////////
    // Window timing and counting, side by side
    ////////////////////////////////////////////////////////////

    gate_timer #(
        .gate_cycles (gate_cycles)
    ) i_gate_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .gate_open (gate),
        .gate_done (gate_done)
    );

    // Counts only while the window is open
    decade_counter i_decade_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .pulse     (pulse),
        .gate_open (gate),
        .count     (count)
    );

    ////////////////////////////////////////////////////////////
    // Host readout
    ////////////////////////////////////////////////////////////

    result_readout i_result_readout (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .gate_done (gate_done),
        .count     (count),
        .result    (result),
        .req       (req),
        .ack       (ack)
    );

endmodule

/* sim/tb_pulse_meter_tasks.svh */
////////////////////////////////////////////////////////////
// Stimulus and host side
////////////////////////////////////////////////////////////

// Expected BCD count for a plain pulse total
function automatic pulse_meter_pkg::bcd_count_t to_bcd(input int value);
    pulse_meter_pkg::bcd_count_t bcd;
    int                          rest;
    bcd  = '0;
    rest = value;
    for (int i = 0; i < pulse_meter_pkg::num_digits; i++) begin
        bcd.digits[i] = pulse_meter_pkg::bcd_digit_t'(rest % 10);
        rest = rest / 10;
    end
    return bcd;
endfunction

// Joins a window that has just opened or waits for the next one
task automatic drive_pulses(input int n, input int gap);
    @(negedge clk);
    while (!(gate && window_age <= 5)) begin
        @(negedge clk);
    end
    while (window_age < 10) begin
        @(negedge clk);
    end
    repeat (n) begin
        pulse = 1'b1;
        repeat (2) @(negedge clk);
        pulse = 1'b0;
        repeat (2 + gap) @(negedge clk);
    end
    if (!gate || window_age > tb_gate_cycles - 10) begin
        $display("%s: pulse burst ran too close to the end of the window", test_name);
        test_errors++;
    end
endtask

// Four-phase handshake as the host
task automatic collect_result(output pulse_meter_pkg::meas_result_t res);
    int waited;
    res    = '0;
    waited = 0;
    @(negedge clk);
    while (!req && waited < 3 * (tb_gate_cycles + 1)) begin
        @(negedge clk);
        waited++;
    end
    if (!req) begin
        $display("%s: req never rose after the window closed", test_name);
        test_errors++;
        return;
    end
    res    = result;
    ack    = 1'b1;
    waited = 0;
    @(negedge clk);
    while (req && waited < 10) begin
        @(negedge clk);
        waited++;
    end
    if (req) begin
        $display("%s: req stayed high after ack was raised", test_name);
        test_errors++;
    end
    ack = 1'b0;
endtask

task automatic check_count(input pulse_meter_pkg::bcd_count_t expected,
                           input pulse_meter_pkg::bcd_count_t actual);
    if (actual !== expected) begin
        $display("error: %s: count expected ovf=%b digits=%h actual ovf=%b digits=%h",
                 test_name, expected.overflow, expected.digits,
                 actual.overflow, actual.digits);
        test_errors++;
    end
endtask

task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("error: %s: %s expected %b actual %b", test_name, what, expected, actual);
        test_errors++;
    end
endtask

task automatic measure_window(input int n, input int gap, input logic exp_missed);
    pulse_meter_pkg::meas_result_t res;
    drive_pulses(n, gap);
    collect_result(res);
    check_count(to_bcd(n), res.count);
    check_flag("missed", exp_missed, res.missed);
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic idle_after_reset();
    start_test("idle_after_reset");
    repeat (20) begin
        @(negedge clk);
        check_flag("gate", 1'b0, gate);
        check_flag("req", 1'b0, req);
        check_count(to_bcd(0), result.count);
        check_flag("missed", 1'b0, result.missed);
    end
    en = 1'b1;
    @(negedge clk);
    check_flag("gate after enable", 1'b1, gate);
    finish_test();
endtask

task automatic single_window();
    start_test("single_window");
    measure_window(37, 0, 1'b0);
    finish_test();
endtask

// 9 then 10 crosses into the tens digit
task automatic decade_carry();
    start_test("decade_carry");
    measure_window(9, 0, 1'b0);
    measure_window(10, 0, 1'b0);
    measure_window(19, 0, 1'b0);
    finish_test();
endtask

task automatic back_pressure();
    pulse_meter_pkg::meas_result_t res;
    int                            waited;
    start_test("back_pressure");
    drive_pulses(12, 0);
    // Host still silent when the second window ends
    drive_pulses(7, 1);
    waited = 0;
    while (gate && waited < tb_gate_cycles) begin
        @(negedge clk);
        waited++;
    end
    collect_result(res);
    check_count(to_bcd(12), res.count);
    check_flag("missed", 1'b0, res.missed);
    measure_window(23, 0, 1'b1);
    measure_window(5, 2, 1'b0);
    finish_test();
endtask

task automatic random_bursts();
    int n;
    int gap;
    int max_gap;
    start_test("random_bursts");
    repeat (6) begin
        n       = $unsigned($random(seed)) % 46;
        // Widest gap that still ends the burst in time
        max_gap = (n > 0) ? (tb_gate_cycles - 20) / n - 4 : 0;
        gap     = (max_gap > 0) ? $unsigned($random(seed)) % (max_gap + 1) : 0;
        measure_window(n, gap, 1'b0);
    end
    finish_test();
endtask

task automatic disable_mid_window();
    start_test("disable_mid_window");
    drive_pulses(20, 0);
    // First result left pending so req is high when en drops
    drive_pulses(8, 0);
    check_flag("req before disable", 1'b1, req);
    check_count(to_bcd(20), result.count);
    en = 1'b0;
    repeat (3) begin
        @(negedge clk);
        check_flag("gate", 1'b0, gate);
        check_flag("req", 1'b0, req);
        check_count(to_bcd(0), result.count);
        check_flag("missed", 1'b0, result.missed);
    end
    en = 1'b1;
    measure_window(25, 1, 1'b0);
    finish_test();
endtask

/* sim/tb_pulse_meter.sv */
module tb_pulse_meter;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int tb_gate_cycles = 200;
    localparam int num_tests      = 6;

    // Twenty window periods of 8 ns cycles for every test
    localparam longint watchdog_ns = longint'(20) * num_tests * (tb_gate_cycles + 1) * 8;

    logic                          clk;
    logic                          rst_n;
    logic                          en;
    logic                          pulse;
    logic                          ack;
    logic                          req;
    logic                          gate;
    pulse_meter_pkg::meas_result_t result;

    // Negedges already seen inside the current open window
    int     window_age;
    string  test_name;
    int     test_errors;
    int     tests_passed;
    int     tests_failed;
    integer seed;

    pulse_meter_top #(
        .gate_cycles (tb_gate_cycles)
    ) i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .pulse  (pulse),
        .ack    (ack),
        .result (result),
        .req    (req),
        .gate   (gate)
    );

    ////////////////////////////////////////////////////////////
    // Clock and window position
    ////////////////////////////////////////////////////////////

    always #4 clk = ~clk;

    always @(negedge clk) begin
        window_age <= gate ? window_age + 1 : 0;
    end

    ////////////////////////////////////////////////////////////
    // Test bookkeeping
    ////////////////////////////////////////////////////////////

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    `include "tb_pulse_meter_tasks.svh"

    ////////////////////////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the test sequence finished");
        $display("STATUS: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        en           = 1'b0;
        pulse        = 1'b0;
        ack          = 1'b0;
        seed         = 36711;
        tests_passed = 0;
        tests_failed = 0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        single_window();
        decade_carry();
        back_pressure();
        random_bursts();
        disable_mid_window();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* pulse_meter_top.f */
+incdir+sim
hw/pulse_meter_pkg.sv
hw/gate_timer.sv
hw/decade_counter.sv
hw/result_readout.sv
hw/pulse_meter_top.sv
sim/tb_pulse_meter.sv

/* Makefile */
# Verilator build and run for the pulse meter testbench

VERILATOR ?= verilator
TOP       ?= tb_pulse_meter
FILELIST  ?= pulse_meter_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= STATUS: PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
